// ==== logic/histo_pkg.sv ====
`default_nettype none

package histo_pkg;

    // Width of an index over n items with at least one bit.
    function automatic int index_bits(input int n);
        int bits;
        bits = (n > 1) ? $clog2(n) : 1;
        return bits;
    endfunction

    // Counter words in the histogram memory.
    function automatic int mem_depth(input int pixels, input int bin_bits);
        int depth;
        depth = pixels << bin_bits;
        return depth;
    endfunction

    localparam int bin_bits_def       = 3;    // 8 time bins.
    localparam int count_bits_def     = 3;    // Saturates at 7.
    localparam int pixels_def         = 4;
    localparam int hits_per_pixel_def = 5;
    localparam int acqs_def           = 2;

    localparam int pixel_bits_def = index_bits(pixels_def);

endpackage

`default_nettype wire

// ==== logic/hit_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface hit_bus_if #(
    parameter int bin_bits   = histo_pkg::bin_bits_def,
    parameter int pixel_bits = histo_pkg::pixel_bits_def
);

    logic                  valid;        // One cycle per hit.
    logic [pixel_bits-1:0] pixel;
    logic [bin_bits-1:0]   bin;
    logic                  frame_end;    // Last hit of the frame.

    modport src (
        output valid,
        output pixel,
        output bin,
        output frame_end
    );

    modport dst (
        input valid,
        input pixel,
        input bin,
        input frame_end
    );

endinterface

`default_nettype wire

// ==== logic/hit_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module hit_sequencer #(
    parameter int bin_bits       = histo_pkg::bin_bits_def,
    parameter int pixels         = histo_pkg::pixels_def,
    parameter int hits_per_pixel = histo_pkg::hits_per_pixel_def,
    parameter int acqs           = histo_pkg::acqs_def,
    localparam int pixel_bits    = histo_pkg::index_bits(pixels)
) (
    input  logic                clk,
    input  logic                res,
    input  logic                hit,
    input  logic [bin_bits-1:0] bin,
    input  logic                release_pulse,
    input  logic                clear_done,
    output logic                busy,
    hit_bus_if.src              hb
);

    import histo_pkg::*;

    localparam int hit_bits = index_bits(hits_per_pixel);
    localparam int acq_bits = index_bits(acqs);

    localparam logic [hit_bits-1:0]   last_hit   = hit_bits'(hits_per_pixel - 1);
    localparam logic [pixel_bits-1:0] last_pixel = pixel_bits'(pixels - 1);
    localparam logic [acq_bits-1:0]   last_acq   = acq_bits'(acqs - 1);

    typedef enum logic [1:0] {
        st_clearing,
        st_counting,
        st_waiting
    } state_t;

    state_t state;

    logic [hit_bits-1:0]   hit_cnt;
    logic [pixel_bits-1:0] pixel_cnt;
    logic [acq_bits-1:0]   acq_cnt;

    logic accept;
    logic pixel_wrap;
    logic acq_wrap;
    logic frame_wrap;

    // Hits only count while no clear or readout is in progress.
    assign accept     = hit & (state == st_counting);
    assign pixel_wrap = (hit_cnt == last_hit);
    assign acq_wrap   = pixel_wrap & (pixel_cnt == last_pixel);
    assign frame_wrap = acq_wrap & (acq_cnt == last_acq);

    assign busy = (state != st_counting);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state        <= st_clearing;
            hit_cnt      <= '0;
            pixel_cnt    <= '0;
            acq_cnt      <= '0;
            hb.valid     <= 1'b0;
            hb.frame_end <= 1'b0;
        end else begin
            hb.valid     <= accept;
            hb.frame_end <= accept & frame_wrap;

            case (state)
                st_clearing: begin
                    if (clear_done) begin
                        state <= st_counting;
                    end
                end
                st_counting: begin
                    if (accept && frame_wrap) begin
                        state <= st_waiting;
                    end
                end
                st_waiting: begin
                    if (release_pulse) begin
                        state <= st_counting;
                    end
                end
                default: state <= st_clearing;
            endcase

            if (accept) begin
                if (pixel_wrap) begin
                    hit_cnt <= '0;
                    if (acq_wrap) begin
                        pixel_cnt <= '0;
                        acq_cnt   <= frame_wrap ? '0 : acq_cnt + 1'b1;
                    end else begin
                        pixel_cnt <= pixel_cnt + 1'b1;
                    end
                end else begin
                    hit_cnt <= hit_cnt + 1'b1;
                end
            end
        end
    end

    // Pixel tag is the one in effect when the hit arrived.
    always_ff @(posedge clk) begin
        if (accept) begin
            hb.pixel <= pixel_cnt;
            hb.bin   <= bin;
        end
    end

endmodule

`default_nettype wire

// ==== logic/bin_accumulator.sv ====
`timescale 1ns/1ps
`default_nettype none

module bin_accumulator #(
    parameter int bin_bits     = histo_pkg::bin_bits_def,
    parameter int count_bits   = histo_pkg::count_bits_def,
    parameter int pixels       = histo_pkg::pixels_def,
    localparam int pixel_bits  = histo_pkg::index_bits(pixels),
    localparam int addr_bits   = pixel_bits + bin_bits
) (
    input  logic                  clk,
    input  logic                  res,
    hit_bus_if.dst                hb,
    input  logic                  rd_en,
    input  logic [addr_bits-1:0]  rd_addr,
    output logic [count_bits-1:0] rd_data,
    output logic                  frame_written,
    output logic                  clear_done
);

    import histo_pkg::*;

    localparam int depth = mem_depth(pixels, bin_bits);

    localparam logic [addr_bits-1:0]  last_addr = addr_bits'(depth - 1);
    localparam logic [count_bits-1:0] count_max = '1;

    logic [count_bits-1:0] mem [depth];
    logic [count_bits-1:0] mem_q;

    logic [addr_bits-1:0] hit_addr;
    logic [addr_bits-1:0] rd_sel;

    logic                 s1_valid;    // Read stage of the RMW.
    logic                 s1_end;
    logic [addr_bits-1:0] s1_addr;

    logic                  fwd;
    logic [count_bits-1:0] fwd_data;
    logic [count_bits-1:0] old_count;
    logic [count_bits-1:0] new_count;

    logic                 sweeping;
    logic [addr_bits-1:0] sweep_addr;

    // Pixel-major layout with the bins of one pixel adjacent.
    assign hit_addr = {hb.pixel, hb.bin};

    // Readout only runs while hits are blocked.
    assign rd_sel = rd_en ? rd_addr : hit_addr;

    // The word just written is newer than what memory returned.
    assign old_count = fwd ? fwd_data : mem_q;
    assign new_count = (old_count == count_max) ? old_count : old_count + 1'b1;

    assign rd_data = mem_q;

    always_ff @(posedge clk) begin
        mem_q <= mem[rd_sel];
        if (sweeping) begin
            mem[sweep_addr] <= '0;
        end else if (rd_en) begin
            mem[rd_addr] <= '0;    // Clear on read.
        end else if (s1_valid) begin
            mem[s1_addr] <= new_count;
        end
        s1_addr  <= hit_addr;
        fwd_data <= new_count;
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1_valid      <= 1'b0;
            s1_end        <= 1'b0;
            fwd           <= 1'b0;
            frame_written <= 1'b0;
            sweeping      <= 1'b1;
            sweep_addr    <= '0;
            clear_done    <= 1'b0;
        end else begin
            s1_valid      <= hb.valid;
            s1_end        <= hb.valid & hb.frame_end;
            fwd           <= hb.valid & s1_valid & (s1_addr == hit_addr);
            frame_written <= s1_end;    // Final write lands with this edge.
            clear_done    <= 1'b0;

            if (sweeping) begin
                if (sweep_addr == last_addr) begin
                    sweeping   <= 1'b0;
                    clear_done <= 1'b1;
                end else begin
                    sweep_addr <= sweep_addr + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/histo_readout.sv ====
`timescale 1ns/1ps
`default_nettype none

module histo_readout #(
    parameter int bin_bits     = histo_pkg::bin_bits_def,
    parameter int count_bits   = histo_pkg::count_bits_def,
    parameter int pixels       = histo_pkg::pixels_def,
    localparam int pixel_bits  = histo_pkg::index_bits(pixels),
    localparam int addr_bits   = pixel_bits + bin_bits
) (
    input  logic                  clk,
    input  logic                  res,
    input  logic                  frame_written,
    output logic                  rd_en,
    output logic [addr_bits-1:0]  rd_addr,
    input  logic [count_bits-1:0] rd_data,
    output logic                  count_valid,
    output logic [count_bits-1:0] count,
    output logic [pixel_bits-1:0] count_pixel,
    output logic [bin_bits-1:0]   count_bin,
    output logic                  frame_done,
    output logic                  release_pulse
);

    import histo_pkg::*;

    localparam int depth = mem_depth(pixels, bin_bits);

    localparam logic [addr_bits-1:0] last_addr = addr_bits'(depth - 1);

    logic                 walking;
    logic [addr_bits-1:0] addr;
    logic [addr_bits-1:0] addr_q;    // Labels the returning word.
    logic                 valid_q;

    // First read goes out in the frame_written cycle itself.
    assign rd_en   = frame_written | walking;
    assign rd_addr = addr;

    assign count_valid   = valid_q;
    assign count         = rd_data;
    assign count_pixel   = addr_q[addr_bits-1 -: pixel_bits];
    assign count_bin     = addr_q[bin_bits-1:0];
    assign release_pulse = frame_done;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            walking    <= 1'b0;
            addr       <= '0;
            valid_q    <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            valid_q    <= rd_en;
            frame_done <= valid_q & (addr_q == last_addr);

            if (rd_en) begin
                if (addr == last_addr) begin
                    addr    <= '0;    // Ready for the next frame.
                    walking <= 1'b0;
                end else begin
                    addr    <= addr + 1'b1;
                    walking <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        addr_q <= addr;
    end

endmodule

`default_nettype wire

// ==== logic/histo_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module histo_top #(
    parameter int bin_bits       = histo_pkg::bin_bits_def,
    parameter int count_bits     = histo_pkg::count_bits_def,
    parameter int pixels         = histo_pkg::pixels_def,
    parameter int hits_per_pixel = histo_pkg::hits_per_pixel_def,
    parameter int acqs           = histo_pkg::acqs_def,
    localparam int pixel_bits    = histo_pkg::index_bits(pixels),
    localparam int addr_bits     = pixel_bits + bin_bits
) (
    input  logic                  clk,
    input  logic                  res,
    input  logic                  hit,
    input  logic [bin_bits-1:0]   bin,
    output logic                  busy,
    output logic                  count_valid,
    output logic [count_bits-1:0] count,
    output logic [pixel_bits-1:0] count_pixel,
    output logic [bin_bits-1:0]   count_bin,
    output logic                  frame_done
);

    logic                  rd_en;
    logic [addr_bits-1:0]  rd_addr;
    logic [count_bits-1:0] rd_data;
    logic                  frame_written;
    logic                  clear_done;
    logic                  release_pulse;

    hit_bus_if #(
        .bin_bits   (bin_bits),
        .pixel_bits (pixel_bits)
    ) hb ();

    hit_sequencer #(
        .bin_bits       (bin_bits),
        .pixels         (pixels),
        .hits_per_pixel (hits_per_pixel),
        .acqs           (acqs)
    ) u_seq (
        .clk           (clk),
        .res           (res),
        .hit           (hit),
        .bin           (bin),
        .release_pulse (release_pulse),
        .clear_done    (clear_done),
        .busy          (busy),
        .hb            (hb.src)
    );

    bin_accumulator #(
        .bin_bits   (bin_bits),
        .count_bits (count_bits),
        .pixels     (pixels)
    ) u_acc (
        .clk           (clk),
        .res           (res),
        .hb            (hb.dst),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .frame_written (frame_written),
        .clear_done    (clear_done)
    );

    histo_readout #(
        .bin_bits   (bin_bits),
        .count_bits (count_bits),
        .pixels     (pixels)
    ) u_rd (
        .clk           (clk),
        .res           (res),
        .frame_written (frame_written),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .count_valid   (count_valid),
        .count         (count),
        .count_pixel   (count_pixel),
        .count_bin     (count_bin),
        .frame_done    (frame_done),
        .release_pulse (release_pulse)
    );

endmodule

`default_nettype wire

// ==== test/histo_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module histo_tb;

    import histo_pkg::*;

    localparam int nbins = 1 << bin_bits_def;
    localparam int depth = pixels_def * nbins;
    localparam int cmax  = (1 << count_bits_def) - 1;

    logic                      clk = 1'b0;
    logic                      res;
    logic                      hit;
    logic [bin_bits_def-1:0]   bin;
    logic                      busy;
    logic                      count_valid;
    logic [count_bits_def-1:0] count;
    logic [pixel_bits_def-1:0] count_pixel;
    logic [bin_bits_def-1:0]   count_bin;
    logic                      frame_done;

    logic [15:0] recs [256];         // Packed records from the cases file.
    logic [31:0] got [depth];        // Last streamed table.
    int          rd_idx = 0;
    int          frames_done = 0;
    int          cycles = 0;
    int          limit = 1000;
    integer      seed = 32'hd292a161;

    histo_top uut (.*);

    always #2 clk = ~clk;

    task automatic abort_run(input string what);
        $display("ERROR: %s", what);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped.");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "Simulation stopped.");
        end
    endtask

    // Drives one hit after some idle cycles and checks the busy level it meets.
    task automatic send_hit(input logic [bin_bits_def-1:0] b, input logic when_busy,
                            input int gap);
        repeat (gap) begin
            @(posedge clk);
            hit <= 1'b0;
        end
        @(posedge clk);
        hit <= 1'b1;
        bin <= b;
        @(negedge clk);
        check_value("busy", busy, when_busy);
    endtask

    always @(negedge clk) begin
        if (rd_idx > 0 && rd_idx < depth) begin
            check_value("count_valid", count_valid, 1'b1);    // The walk has no gaps.
        end
        if (rd_idx == depth) begin
            check_value("frame_done", frame_done, 1'b1);
        end
        if (count_valid) begin
            if (rd_idx >= depth) begin
                abort_run("count_valid seen after the whole table was streamed");
            end
            check_value("count_pixel", count_pixel, rd_idx / nbins);    // Pixel-major walk.
            check_value("count_bin", count_bin, rd_idx % nbins);
            got[rd_idx] = count;
            rd_idx++;
        end
        if (frame_done) begin
            check_value("counters before frame_done", rd_idx, depth);
            rd_idx = 0;
            frames_done++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            abort_run("timeout, the frames were not read out in time");
        end
    end

    initial begin : main
        int          idx;
        int          a;
        int          p;
        int          n_hits;
        int          n_tab;
        int          frame;
        int          gap;
        int          prev_bin;
        logic [3:0]  kind;
        int          hq [$];
        int          model [depth];
        logic [31:0] expected [depth];
        res = 1'b0;
        hit = 1'b0;
        bin = '0;
        for (idx = 0; idx < 256; idx++) begin
            recs[idx] = '0;
        end
        $readmemh("test/histo_cases.txt", recs);
        n_hits = 0;
        n_tab = 0;
        for (idx = 0; idx < 256; idx++) begin
            kind = recs[idx][15:12];
            n_hits += (kind == 4'h1 || kind == 4'h2) ? 1 : 0;
            n_tab += (kind == 4'h3) ? 1 : 0;
        end
        // Reset, clear sweep, worst-case gaps, and one readout per frame.
        limit = 2 * (16 + depth + n_hits * 4 + (n_tab / depth + 1) * (depth + 8));
        repeat (16) @(posedge clk);
        res <= 1'b1;
        idx = 0;
        frame = 0;
        while (recs[idx] != '0) begin
            hq.delete();
            for (a = 0; a < depth; a++) begin
                model[a] = 0;
                expected[a] = 'x;
            end
            @(negedge clk);
            while (busy) @(negedge clk);
            prev_bin = -1;
            while (recs[idx][15:12] == 4'h1 || recs[idx][15:12] == 4'h2) begin
                kind = recs[idx][15:12];
                gap = (recs[idx][3:0] == prev_bin) ? 0 : $unsigned($random(seed)) % 4;
                send_hit(recs[idx][bin_bits_def-1:0], kind == 4'h2, gap);
                if (kind == 4'h1) begin
                    hq.push_back(recs[idx][bin_bits_def-1:0]);
                end
                prev_bin = recs[idx][3:0];
                idx++;
            end
            @(posedge clk);
            hit <= 1'b0;
            n_tab = 0;
            while (recs[idx][15:12] == 4'h3) begin
                expected[recs[idx][11:8] * nbins + recs[idx][7:4]] = recs[idx][3:0];
                n_tab++;
                idx++;
            end
            if (recs[idx][15:12] > 4'h3) begin
                abort_run("unknown record type in the cases file");
            end
            check_value("table records in cases file", n_tab, depth);
            for (a = 0; a < hq.size(); a++) begin
                p = (a / hits_per_pixel_def) % pixels_def;    // Hit order picks the pixel.
                if (model[p * nbins + hq[a]] < cmax) begin
                    model[p * nbins + hq[a]]++;
                end
            end
            while (frames_done == frame) @(negedge clk);
            for (a = 0; a < depth; a++) begin
                check_value($sformatf("cases file p%0d b%0d", a / nbins, a % nbins),
                            model[a], expected[a]);
                check_value($sformatf("count p%0d b%0d", a / nbins, a % nbins),
                            got[a], expected[a]);
            end
            frame++;
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/histo_cases.txt ====
// Records: 100b counted hit on bin b, 200b hit sent while busy,
// 3pbv expected count v for pixel p and bin b, 0000 ends the file.
// Frame 1, pixel 0 bin 5 saturates.
1005 1005 1005 1005 1005 1002 1002 1002 1003 1007
1001 1001 1006 1006 1006 1004 1004 1004 1004 1004
1005 1005 1005 1005 1005 1000 1002 1004 1006 1007
1001 1003 1003 1003 1000 1004 1007 1007 1000 1001
2001 2005 2005
3000 3010 3020 3030 3040 3057 3060 3070
3101 3110 3124 3131 3141 3150 3161 3172
3201 3213 3220 3233 3240 3250 3263 3270
3301 3311 3320 3330 3346 3350 3360 3372
// Frame 2, none of frame 1 may remain.
1000 1001 1002 1003 1004 1007 1007 1007 1007 1007
1002 1002 1005 1005 1005 1006 1006 1006 1006 1006
1005 1006 1007 1000 1001 1003 1003 1000 1000 1000
1002 1004 1004 1004 1004 1001 1002 1003 1006 1006
2007 2007
3002 3012 3021 3031 3041 3051 3061 3071
3103 3110 3120 3132 3140 3150 3160 3175
3200 3210 3223 3230 3244 3253 3260 3270
3300 3311 3321 3331 3340 3350 3367 3370
0000

// ==== list.f ====
logic/histo_pkg.sv
logic/hit_bus_if.sv
logic/hit_sequencer.sv
logic/bin_accumulator.sv
logic/histo_readout.sv
logic/histo_top.sv
test/histo_tb.sv

// ==== Bender.yml ====
package:
  name: histo

sources:
  - logic/histo_pkg.sv
  - logic/hit_bus_if.sv
  - logic/hit_sequencer.sv
  - logic/bin_accumulator.sv
  - logic/histo_readout.sv
  - logic/histo_top.sv
  - target: test
    files:
      - test/histo_tb.sv
